/* issue_stage.f */
src/issue_pkg.sv
src/instr_decoder.sv
src/operand_resolver.sv
src/ldi_sequencer.sv
src/issue_dispatch.sv
src/issue_stage.sv
bench/issue_stage_tb.sv

/* Makefile */
TOP = issue_stage_tb
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f issue_stage.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f issue_stage.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* bench/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb import issue_pkg::*;;

	localparam int tag_width = 3;
	localparam int run_cycles = 3000;

	logic clk;
	logic rst_n;
	instr_word_t instr;
	logic instr_valid;
	logic cdb_valid;
	logic [tag_width-1:0] cdb_tag;
	lc3b_word cdb_data;
	logic sr1_busy;
	lc3b_word sr1_data;
	logic [tag_width-1:0] sr1_rob_entry;
	logic sr2_busy;
	lc3b_word sr2_data;
	logic [tag_width-1:0] sr2_rob_entry;
	lc3b_word rob_sr1_value;
	logic rob_sr1_valid;
	lc3b_word rob_sr2_value;
	logic rob_sr2_valid;
	logic [2:0] alu_busy;
	logic ldst_full;
	logic rob_full;
	logic [tag_width-1:0] rob_addr;
	lc3b_reg rd_sr1;
	lc3b_reg rd_sr2;
	logic [tag_width-1:0] rob_sr1_read_addr;
	logic [tag_width-1:0] rob_sr2_read_addr;
	logic stall;
	logic rs_write;
	logic [1:0] rs_station_id;
	lc3b_opcode rs_op;
	lc3b_word rs_vj;
	logic rs_vj_valid;
	logic [tag_width-1:0] rs_qj;
	lc3b_word rs_vk;
	logic rs_vk_valid;
	logic [tag_width-1:0] rs_qk;
	logic ldst_write;
	lc3b_opcode ldst_op;
	lc3b_word ldst_offset;
	lc3b_word ldst_base;
	logic ldst_base_valid;
	logic [tag_width-1:0] ldst_qbase;
	lc3b_word ldst_src;
	logic ldst_src_valid;
	logic [tag_width-1:0] ldst_qsrc;
	logic rob_write;
	lc3b_opcode rob_opcode;
	lc3b_reg rob_dest;
	logic reg_write_busy;
	lc3b_reg reg_dest;
	logic [tag_width-1:0] reg_rob_entry;

	// Reference model state
	logic [15:0] w;
	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_ldi;
	logic hazard;
	logic go;
	logic first_exp;
	logic second_exp;
	logic pend_model;
	logic [tag_width-1:0] saved_model;
	logic [1:0] station_exp;
	lc3b_word imm5_exp;
	lc3b_word offset_exp;
	logic [19:0] src1_exp;    // {valid, value, tag}
	logic [19:0] src2_exp;
	logic [19:0] vk_exp;
	logic [19:0] ldi_base_exp;
	int error_count;
	int alu_count;
	int load_count;
	int store_count;
	int ldi_count;

	issue_stage #(.tag_width(tag_width)) issue_stage_i (.*);

	always #50 clk = ~clk;

	function automatic lc3b_opcode kept_opcode(input int unsigned pick);
		case (pick % 6)
			0: return op_add;
			1: return op_and;
			2: return op_not;
			3: return op_ldr;
			4: return op_str;
			default: return op_ldi;
		endcase
	endfunction

	// CDB first, then ROB, then the register itself, else wait on its tag
	function automatic logic [19:0] expect_operand(input logic busy, input lc3b_word data,
		input logic [2:0] entry, input lc3b_word rob_val, input logic rob_ok,
		input logic bus_ok, input logic [2:0] bus_tag, input lc3b_word bus_data);
		if (!busy)
			return {1'b1, data, 3'd0};
		if (bus_ok && bus_tag == entry)
			return {1'b1, bus_data, 3'd0};
		if (rob_ok)
			return {1'b1, rob_val, 3'd0};
		return {1'b0, 16'h0000, entry};
	endfunction

	// Value only counts when valid, tag only when waiting
	function automatic logic [19:0] seen_operand(input logic want_valid, input logic valid,
		input lc3b_word value, input logic [2:0] tag);
		return {valid, want_valid ? value : 16'h0000, want_valid ? 3'd0 : tag};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count++;
		$display("[ERROR] %s expected %h actual %h", name, expected, actual);
	endtask

	assign w = instr;
	assign is_alu = w[15:12] == op_add || w[15:12] == op_and || w[15:12] == op_not;
	assign is_load = w[15:12] == op_ldr;
	assign is_store = w[15:12] == op_str;
	assign is_ldi = w[15:12] == op_ldi;
	assign hazard = instr_valid &&
		(rob_full || (is_alu && alu_busy == 3'b111) || (!is_alu && ldst_full));
	assign go = instr_valid && !hazard;
	assign first_exp = go && is_ldi && !pend_model;
	assign second_exp = go && is_ldi && pend_model;
	assign station_exp = !alu_busy[0] ? 2'd0 : (!alu_busy[1] ? 2'd1 : 2'd2);
	assign imm5_exp = {{11{w[4]}}, w[4:0]};
	assign offset_exp = {{9{w[5]}}, w[5:0], 1'b0};    // Word offset in bytes

	always_comb
	begin
		src1_exp = expect_operand(sr1_busy, sr1_data, sr1_rob_entry, rob_sr1_value,
			rob_sr1_valid, cdb_valid, cdb_tag, cdb_data);
		src2_exp = expect_operand(sr2_busy, sr2_data, sr2_rob_entry, rob_sr2_value,
			rob_sr2_valid, cdb_valid, cdb_tag, cdb_data);
		vk_exp = (w[5] || w[15:12] == op_not) ? {1'b1, imm5_exp, 3'd0} : src2_exp;
		if (cdb_valid && cdb_tag == saved_model)
			ldi_base_exp = {1'b1, cdb_data, 3'd0};
		else
			ldi_base_exp = {1'b0, 16'h0000, saved_model};
	end

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			pend_model <= 1'b0;
			saved_model <= '0;
		end
		else if (first_exp)
		begin
			pend_model <= 1'b1;
			saved_model <= rob_addr;
		end
		else if (second_exp)
			pend_model <= 1'b0;
		if (rst_n && go)
		begin
			alu_count <= alu_count + int'(is_alu);
			load_count <= load_count + int'(is_load);
			store_count <= store_count + int'(is_store);
			ldi_count <= ldi_count + int'(second_exp);
		end
	end

	stall_level: assert property (@(posedge clk) disable iff (!rst_n)
		stall == (hazard || first_exp))
		else report_mismatch("stall_level", $sampled(hazard || first_exp), $sampled(stall));

	strobes_held: assert property (@(posedge clk) disable iff (!rst_n)
		!go |-> {rs_write, ldst_write, rob_write, reg_write_busy} == 4'b0000)
		else report_mismatch("strobes_held", 64'h0,
			$sampled({rs_write, ldst_write, rob_write, reg_write_busy}));

	// Every issue writes the ROB, and lookups follow the register entries
	rob_entry: assert property (@(posedge clk) disable iff (!rst_n)
		go |-> {rob_write, rob_opcode, rob_sr1_read_addr, rob_sr2_read_addr} ==
		{1'b1, w[15:12], sr1_rob_entry, sr2_rob_entry})
		else report_mismatch("rob_entry", $sampled({1'b1, w[15:12], sr1_rob_entry,
			sr2_rob_entry}), $sampled({rob_write, rob_opcode, rob_sr1_read_addr,
			rob_sr2_read_addr}));

	alu_issue: assert property (@(posedge clk) disable iff (!rst_n)
		go && is_alu |-> {rs_write, ldst_write, rs_station_id, rs_op, rob_write, rob_dest,
		reg_write_busy, reg_dest, reg_rob_entry} == {2'b10, station_exp, w[15:12], 1'b1,
		w[11:9], 1'b1, w[11:9], rob_addr})
		else report_mismatch("alu_issue", $sampled({2'b10, station_exp, w[15:12], 1'b1,
			w[11:9], 1'b1, w[11:9], rob_addr}), $sampled({rs_write, ldst_write,
			rs_station_id, rs_op, rob_write, rob_dest, reg_write_busy, reg_dest, reg_rob_entry}));

	alu_vj: assert property (@(posedge clk) disable iff (!rst_n)
		go && is_alu |-> seen_operand(src1_exp[19], rs_vj_valid, rs_vj, rs_qj) == src1_exp)
		else report_mismatch("alu_vj", $sampled(src1_exp),
			$sampled(seen_operand(src1_exp[19], rs_vj_valid, rs_vj, rs_qj)));

	alu_vk: assert property (@(posedge clk) disable iff (!rst_n)
		go && is_alu |-> seen_operand(vk_exp[19], rs_vk_valid, rs_vk, rs_qk) == vk_exp)
		else report_mismatch("alu_vk", $sampled(vk_exp),
			$sampled(seen_operand(vk_exp[19], rs_vk_valid, rs_vk, rs_qk)));

	alu_reads: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid && is_alu |-> {rd_sr1, rd_sr2} == {w[8:6], w[2:0]})
		else report_mismatch("alu_reads", $sampled({w[8:6], w[2:0]}), $sampled({rd_sr1, rd_sr2}));

	mem_base: assert property (@(posedge clk) disable iff (!rst_n)
		go && (is_load || is_store || first_exp) |-> {ldst_write, rs_write, ldst_offset,
		seen_operand(src1_exp[19], ldst_base_valid, ldst_base, ldst_qbase), rd_sr1} ==
		{2'b10, offset_exp, src1_exp, w[8:6]})
		else report_mismatch("mem_base", $sampled({2'b10, offset_exp, src1_exp, w[8:6]}),
			$sampled({ldst_write, rs_write, ldst_offset,
			seen_operand(src1_exp[19], ldst_base_valid, ldst_base, ldst_qbase), rd_sr1}));

	load_dest: assert property (@(posedge clk) disable iff (!rst_n)
		go && is_load |-> {ldst_op, rob_write, rob_dest, reg_write_busy, reg_dest,
		reg_rob_entry} == {op_ldr, 1'b1, w[11:9], 1'b1, w[11:9], rob_addr})
		else report_mismatch("load_dest", $sampled({op_ldr, 1'b1, w[11:9], 1'b1, w[11:9],
			rob_addr}), $sampled({ldst_op, rob_write, rob_dest, reg_write_busy, reg_dest,
			reg_rob_entry}));

	store_src: assert property (@(posedge clk) disable iff (!rst_n)
		go && is_store |-> {ldst_op, seen_operand(src2_exp[19], ldst_src_valid, ldst_src,
		ldst_qsrc), rd_sr2, rob_write, rob_dest, reg_write_busy} ==
		{op_str, src2_exp, w[11:9], 1'b1, 3'd0, 1'b0})
		else report_mismatch("store_src", $sampled({op_str, src2_exp, w[11:9], 5'b10000}),
			$sampled({ldst_op, seen_operand(src2_exp[19], ldst_src_valid, ldst_src,
			ldst_qsrc), rd_sr2, rob_write, rob_dest, reg_write_busy}));

	ldi_first_half: assert property (@(posedge clk) disable iff (!rst_n)
		first_exp |-> {stall, ldst_write, ldst_op, rob_write, reg_write_busy} ==
		{2'b11, op_ldr, 2'b10})
		else report_mismatch("ldi_first_half", $sampled({2'b11, op_ldr, 2'b10}),
			$sampled({stall, ldst_write, ldst_op, rob_write, reg_write_busy}));

	// Pointer base from the CDB or a wait on the first half's entry
	ldi_second_half: assert property (@(posedge clk) disable iff (!rst_n)
		second_exp |-> {stall, ldst_write, ldst_offset, seen_operand(ldi_base_exp[19],
		ldst_base_valid, ldst_base, ldst_qbase), reg_write_busy, reg_dest, reg_rob_entry} ==
		{2'b01, 16'h0000, ldi_base_exp, 1'b1, w[11:9], rob_addr})
		else report_mismatch("ldi_second_half", $sampled({2'b01, 16'h0000, ldi_base_exp,
			1'b1, w[11:9], rob_addr}), $sampled({stall, ldst_write, ldst_offset,
			seen_operand(ldi_base_exp[19], ldst_base_valid, ldst_base, ldst_qbase),
			reg_write_busy, reg_dest, reg_rob_entry}));

	task automatic drive_random_cycle();
		logic [2:0] e1;
		logic [2:0] e2;
		logic [15:0] word;
		e1 = 3'($urandom);
		e2 = 3'($urandom);
		if (!(instr_valid && stall))    // Fetch holds a stalled word
		begin
			word = {kept_opcode($urandom), 12'($urandom)};
			if (word[15:12] == op_not)
				word[5:0] = 6'h3f;
			instr <= word;
			instr_valid <= ($urandom % 10) != 0;
		end
		sr1_busy <= 1'($urandom);
		sr1_data <= 16'($urandom);
		sr1_rob_entry <= e1;
		sr2_busy <= 1'($urandom);
		sr2_data <= 16'($urandom);
		sr2_rob_entry <= e2;
		rob_sr1_value <= 16'($urandom);
		rob_sr1_valid <= 1'($urandom);
		rob_sr2_value <= 16'($urandom);
		rob_sr2_valid <= 1'($urandom);
		cdb_valid <= ($urandom % 5) < 3;
		cdb_data <= 16'($urandom);
		case ($urandom % 4)
			0: cdb_tag <= e1;
			1: cdb_tag <= e2;
			2: cdb_tag <= rob_addr;    // Hits a just-saved LDI tag
			default: cdb_tag <= 3'($urandom);
		endcase
		alu_busy <= 3'($urandom);
		ldst_full <= ($urandom % 10) == 0;
		rob_full <= ($urandom % 10) == 0;
		rob_addr <= 3'($urandom);
	endtask

	task automatic finish_held_word(input int limit, output logic timed_out);
		int cycles;
		cycles = 0;
		while (instr_valid && stall && cycles < limit)
		begin
			@(posedge clk);
			rob_full <= 1'b0;
			ldst_full <= 1'b0;
			alu_busy <= 3'b000;
			cycles++;
		end
		timed_out = instr_valid && stall;
	endtask

	initial
	begin
		logic timed_out;
		void'($urandom(3));
		error_count = 0;
		alu_count = 0;
		load_count = 0;
		store_count = 0;
		ldi_count = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		sr1_busy = 1'b0;
		sr1_data = '0;
		sr1_rob_entry = '0;
		sr2_busy = 1'b0;
		sr2_data = '0;
		sr2_rob_entry = '0;
		rob_sr1_value = '0;
		rob_sr1_valid = 1'b0;
		rob_sr2_value = '0;
		rob_sr2_valid = 1'b0;
		alu_busy = 3'b000;
		ldst_full = 1'b0;
		rob_full = 1'b0;
		rob_addr = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (run_cycles)
		begin
			@(posedge clk);
			drive_random_cycle();
		end
		finish_held_word(40, timed_out);
		instr_valid <= 1'b0;
		repeat (4) @(posedge clk);
		if (timed_out)
			$display("Timeout: stall stayed high after all back-pressure was cleared");
		$display("Errors: %0d, issued alu %0d load %0d store %0d ldi %0d", error_count,
			alu_count, load_count, store_count, ldi_count);
		if (timed_out || error_count != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* src/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import issue_pkg::*;
#(
	parameter int tag_width = 3
)
(
	input logic clk,
	input logic rst_n,
	input instr_word_t instr,
	input logic instr_valid,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input lc3b_word cdb_data,
	input logic sr1_busy,
	input lc3b_word sr1_data,
	input logic [tag_width-1:0] sr1_rob_entry,
	input logic sr2_busy,
	input lc3b_word sr2_data,
	input logic [tag_width-1:0] sr2_rob_entry,
	input lc3b_word rob_sr1_value,
	input logic rob_sr1_valid,
	input lc3b_word rob_sr2_value,
	input logic rob_sr2_valid,
	input logic [2:0] alu_busy,
	input logic ldst_full,
	input logic rob_full,
	input logic [tag_width-1:0] rob_addr,
	output lc3b_reg rd_sr1,
	output lc3b_reg rd_sr2,
	output logic [tag_width-1:0] rob_sr1_read_addr,
	output logic [tag_width-1:0] rob_sr2_read_addr,
	output logic stall,
	output logic rs_write,
	output logic [1:0] rs_station_id,
	output lc3b_opcode rs_op,
	output lc3b_word rs_vj,
	output logic rs_vj_valid,
	output logic [tag_width-1:0] rs_qj,
	output lc3b_word rs_vk,
	output logic rs_vk_valid,
	output logic [tag_width-1:0] rs_qk,
	output logic ldst_write,
	output lc3b_opcode ldst_op,
	output lc3b_word ldst_offset,
	output lc3b_word ldst_base,
	output logic ldst_base_valid,
	output logic [tag_width-1:0] ldst_qbase,
	output lc3b_word ldst_src,
	output logic ldst_src_valid,
	output logic [tag_width-1:0] ldst_qsrc,
	output logic rob_write,
	output lc3b_opcode rob_opcode,
	output lc3b_reg rob_dest,
	output logic reg_write_busy,
	output lc3b_reg reg_dest,
	output logic [tag_width-1:0] reg_rob_entry
);

	lc3b_opcode opcode;
	op_class_t op_class;
	lc3b_reg dest_reg;
	logic use_imm;
	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word src1_value;
	logic src1_valid;
	logic [tag_width-1:0] src1_tag;
	lc3b_word src2_value;
	logic src2_valid;
	logic [tag_width-1:0] src2_tag;
	logic ldi_first;
	logic ldi_second;
	logic ldi_pending;
	lc3b_word ldi_base;
	logic ldi_base_valid;
	logic [tag_width-1:0] ldi_tag;

	// ROB is looked up by the producer entry of each source
	assign rob_sr1_read_addr = sr1_rob_entry;
	assign rob_sr2_read_addr = sr2_rob_entry;

	instr_decoder decoder_i
	(
		.instr(instr), .opcode(opcode), .op_class(op_class), .dest_reg(dest_reg),
		.rd_sr1(rd_sr1), .rd_sr2(rd_sr2), .use_imm(use_imm), .imm5(imm5),
		.offset6(offset6)
	);

	operand_resolver #(.tag_width(tag_width)) src1_resolver_i
	(
		.reg_busy(sr1_busy), .reg_data(sr1_data), .reg_rob_entry(sr1_rob_entry),
		.rob_value(rob_sr1_value), .rob_valid(rob_sr1_valid), .cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag), .cdb_data(cdb_data), .value(src1_value),
		.value_valid(src1_valid), .wait_tag(src1_tag)
	);

	operand_resolver #(.tag_width(tag_width)) src2_resolver_i    // SR2 or store data
	(
		.reg_busy(sr2_busy), .reg_data(sr2_data), .reg_rob_entry(sr2_rob_entry),
		.rob_value(rob_sr2_value), .rob_valid(rob_sr2_valid), .cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag), .cdb_data(cdb_data), .value(src2_value),
		.value_valid(src2_valid), .wait_tag(src2_tag)
	);

	ldi_sequencer #(.tag_width(tag_width)) ldi_sequencer_i
	(
		.clk(clk), .rst_n(rst_n), .ldi_first(ldi_first), .ldi_second(ldi_second),
		.cdb_valid(cdb_valid), .rob_addr(rob_addr), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.ldi_pending(ldi_pending), .ldi_base(ldi_base), .ldi_base_valid(ldi_base_valid),
		.ldi_tag(ldi_tag)
	);

	issue_dispatch #(.tag_width(tag_width)) dispatch_i
	(
		.opcode(opcode), .op_class(op_class), .dest_reg(dest_reg), .use_imm(use_imm),
		.imm5(imm5), .offset6(offset6),
		.src1_value(src1_value), .src1_valid(src1_valid), .src1_tag(src1_tag),
		.src2_value(src2_value), .src2_valid(src2_valid), .src2_tag(src2_tag),
		.ldi_pending(ldi_pending), .ldi_base(ldi_base), .ldi_base_valid(ldi_base_valid),
		.ldi_tag(ldi_tag), .instr_valid(instr_valid), .alu_busy(alu_busy),
		.ldst_full(ldst_full), .rob_full(rob_full), .rob_addr(rob_addr),
		.ldi_first(ldi_first), .ldi_second(ldi_second), .stall(stall),
		.rs_write(rs_write), .rs_station_id(rs_station_id), .rs_op(rs_op),
		.rs_vj(rs_vj), .rs_vj_valid(rs_vj_valid), .rs_qj(rs_qj),
		.rs_vk(rs_vk), .rs_vk_valid(rs_vk_valid), .rs_qk(rs_qk),
		.ldst_write(ldst_write), .ldst_op(ldst_op), .ldst_offset(ldst_offset),
		.ldst_base(ldst_base), .ldst_base_valid(ldst_base_valid), .ldst_qbase(ldst_qbase),
		.ldst_src(ldst_src), .ldst_src_valid(ldst_src_valid), .ldst_qsrc(ldst_qsrc),
		.rob_write(rob_write), .rob_opcode(rob_opcode), .rob_dest(rob_dest),
		.reg_write_busy(reg_write_busy), .reg_dest(reg_dest),
		.reg_rob_entry(reg_rob_entry)
	);

endmodule

/* src/issue_dispatch.sv */
`timescale 1ns/1ps

module issue_dispatch import issue_pkg::*;
#(
	parameter int tag_width = 3
)
(
	input lc3b_opcode opcode,
	input op_class_t op_class,
	input lc3b_reg dest_reg,
	input logic use_imm,
	input lc3b_word imm5,
	input lc3b_word offset6,
	input lc3b_word src1_value,
	input logic src1_valid,
	input logic [tag_width-1:0] src1_tag,
	input lc3b_word src2_value,
	input logic src2_valid,
	input logic [tag_width-1:0] src2_tag,
	input logic ldi_pending,
	input lc3b_word ldi_base,
	input logic ldi_base_valid,
	input logic [tag_width-1:0] ldi_tag,
	input logic instr_valid,
	input logic [2:0] alu_busy,
	input logic ldst_full,
	input logic rob_full,
	input logic [tag_width-1:0] rob_addr,
	output logic ldi_first,
	output logic ldi_second,
	output logic stall,
	output logic rs_write,
	output logic [1:0] rs_station_id,
	output lc3b_opcode rs_op,
	output lc3b_word rs_vj,
	output logic rs_vj_valid,
	output logic [tag_width-1:0] rs_qj,
	output lc3b_word rs_vk,
	output logic rs_vk_valid,
	output logic [tag_width-1:0] rs_qk,
	output logic ldst_write,
	output lc3b_opcode ldst_op,
	output lc3b_word ldst_offset,
	output lc3b_word ldst_base,
	output logic ldst_base_valid,
	output logic [tag_width-1:0] ldst_qbase,
	output lc3b_word ldst_src,
	output logic ldst_src_valid,
	output logic [tag_width-1:0] ldst_qsrc,
	output logic rob_write,
	output lc3b_opcode rob_opcode,
	output lc3b_reg rob_dest,
	output logic reg_write_busy,
	output lc3b_reg reg_dest,
	output logic [tag_width-1:0] reg_rob_entry
);

	logic alu_op;
	logic mem_op;
	logic res_stall;
	logic issue_ok;
	logic is_ldi;

	assign alu_op = (op_class == class_alu);
	assign mem_op = (op_class == class_load) || (op_class == class_store) ||
		(op_class == class_ldi);
	assign is_ldi = (op_class == class_ldi);

	// Structural hazards hold everything back
	assign res_stall = instr_valid &&
		(rob_full || (alu_op && (&alu_busy)) || (mem_op && ldst_full));
	assign issue_ok = instr_valid && !res_stall && (op_class != class_none);

	assign ldi_first = issue_ok && is_ldi && !ldi_pending;
	assign ldi_second = issue_ok && is_ldi && ldi_pending;

	assign stall = res_stall || ldi_first;    // First LDI half keeps the word held

	always_comb
	begin
		rs_write = 1'b0;
		rs_station_id = 2'd0;
		rs_op = opcode;
		rs_vj = word_zero;
		rs_vj_valid = 1'b0;
		rs_qj = '0;
		rs_vk = word_zero;
		rs_vk_valid = 1'b0;
		rs_qk = '0;
		ldst_write = 1'b0;
		ldst_op = opcode;
		ldst_offset = word_zero;
		ldst_base = word_zero;
		ldst_base_valid = 1'b0;
		ldst_qbase = '0;
		ldst_src = word_zero;
		ldst_src_valid = 1'b0;
		ldst_qsrc = '0;
		rob_write = 1'b0;
		rob_opcode = opcode;
		rob_dest = '0;
		reg_write_busy = 1'b0;
		reg_dest = '0;
		reg_rob_entry = '0;

		if (issue_ok)
		begin
			rob_write = 1'b1;
			if (alu_op)
			begin
				rs_write = 1'b1;
				if (!alu_busy[0])
					rs_station_id = 2'd0;
				else if (!alu_busy[1])
					rs_station_id = 2'd1;
				else
					rs_station_id = 2'd2;
				rs_vj = src1_value;
				rs_vj_valid = src1_valid;
				rs_qj = src1_tag;
				if (use_imm || opcode == op_not)
				begin
					rs_vk = imm5;    // NOT carries all ones here
					rs_vk_valid = 1'b1;
				end
				else
				begin
					rs_vk = src2_value;
					rs_vk_valid = src2_valid;
					rs_qk = src2_tag;
				end
			end
			else
			begin
				ldst_write = 1'b1;
				ldst_op = (op_class == class_store) ? op_str : op_ldr;
				ldst_offset = ldi_second ? word_zero : offset6;
				if (ldi_second)
				begin
					// Base is the pointer fetched by the first half
					ldst_base = ldi_base;
					ldst_base_valid = ldi_base_valid;
					ldst_qbase = ldi_base_valid ? '0 : ldi_tag;
				end
				else
				begin
					ldst_base = src1_value;
					ldst_base_valid = src1_valid;
					ldst_qbase = src1_tag;
				end
				if (op_class == class_store)
				begin
					ldst_src = src2_value;
					ldst_src_valid = src2_valid;
					ldst_qsrc = src2_tag;
				end
			end

			if (op_class != class_store)
				rob_dest = dest_reg;
			// Register goes busy once the final result owner is known
			if (alu_op || op_class == class_load || ldi_second)
			begin
				reg_write_busy = 1'b1;
				reg_dest = dest_reg;
				reg_rob_entry = rob_addr;
			end
		end
	end

	// Fetch must keep the LDI word until its second half issues
	held_ldi: assert final (!(instr_valid && ldi_pending && op_class != class_ldi))
		else $error("instruction word changed while an LDI was half issued");

endmodule

/* src/ldi_sequencer.sv */
`timescale 1ns/1ps

module ldi_sequencer import issue_pkg::*;
#(
	parameter int tag_width = 3
)
(
	input logic clk,
	input logic rst_n,
	input logic ldi_first,
	input logic ldi_second,
	input logic cdb_valid,
	input logic [tag_width-1:0] rob_addr,
	input logic [tag_width-1:0] cdb_tag,
	input lc3b_word cdb_data,
	output logic ldi_pending,
	output lc3b_word ldi_base,
	output logic ldi_base_valid,
	output logic [tag_width-1:0] ldi_tag
);

	logic [tag_width-1:0] saved_tag;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ldi_pending <= 1'b0;
		else if (ldi_first)
			ldi_pending <= 1'b1;
		else if (ldi_second)
			ldi_pending <= 1'b0;
	end

	// ROB entry of the pointer load
	always_ff @(posedge clk)
	begin
		if (ldi_first)
			saved_tag <= rob_addr;
		else if (ldi_second)
			saved_tag <= '0;
	end

	// Pointer arrives only via the CDB on the second issue
	assign ldi_base = cdb_data;
	assign ldi_base_valid = cdb_valid && (cdb_tag == saved_tag);
	assign ldi_tag = saved_tag;

	pulse_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(ldi_first && ldi_second))
		else $error("ldi_first and ldi_second high together");

	no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		ldi_first |-> !ldi_pending)
		else $error("ldi_first while an LDI is already pending");

endmodule

/* src/operand_resolver.sv */
`timescale 1ns/1ps

module operand_resolver import issue_pkg::*;
#(
	parameter int tag_width = 3
)
(
	input logic reg_busy,
	input lc3b_word reg_data,
	input logic [tag_width-1:0] reg_rob_entry,
	input lc3b_word rob_value,
	input logic rob_valid,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input lc3b_word cdb_data,
	output lc3b_word value,
	output logic value_valid,
	output logic [tag_width-1:0] wait_tag
);

	always_comb
	begin
		value = reg_data;
		value_valid = 1'b1;
		wait_tag = '0;
		if (reg_busy)
		begin
			// Result on the bus this cycle beats the ROB copy
			if (cdb_valid && cdb_tag == reg_rob_entry)
				value = cdb_data;
			else if (rob_valid)
				value = rob_value;    // Done but not yet committed
			else
			begin
				value = word_zero;
				value_valid = 1'b0;
				wait_tag = reg_rob_entry;
			end
		end
	end

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import issue_pkg::*;
(
	input instr_word_t instr,
	output lc3b_opcode opcode,
	output op_class_t op_class,
	output lc3b_reg dest_reg,
	output lc3b_reg rd_sr1,
	output lc3b_reg rd_sr2,
	output logic use_imm,
	output lc3b_word imm5,
	output lc3b_word offset6
);

	// Opcode sits in the same bits in both views
	assign opcode = instr.alu.opcode;

	always_comb
	begin
		case (opcode)
			op_add, op_and, op_not: op_class = class_alu;
			op_ldr: op_class = class_load;
			op_str: op_class = class_store;
			op_ldi: op_class = class_ldi;
			default: op_class = class_none;
		endcase
	end

	always_comb
	begin
		dest_reg = '0;
		rd_sr1 = '0;
		rd_sr2 = '0;
		use_imm = 1'b0;
		imm5 = word_zero;
		offset6 = word_zero;
		case (op_class)
			class_alu:
			begin
				dest_reg = instr.alu.dest;
				rd_sr1 = instr.alu.sr1;
				rd_sr2 = instr.alu.field5[2:0];
				use_imm = instr.alu.imm_flag;
				imm5 = {{(word_width-5){instr.alu.field5[4]}}, instr.alu.field5};
			end
			class_load, class_ldi:
			begin
				dest_reg = instr.mem.data_reg;
				rd_sr1 = instr.mem.base_reg;
				// Word offset, so scale by two
				offset6 = {{(word_width-7){instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0};
			end
			class_store:
			begin
				rd_sr1 = instr.mem.base_reg;
				rd_sr2 = instr.mem.data_reg;    // Store data comes through port 2
				offset6 = {{(word_width-7){instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0};
			end
			default:
			begin
			end
		endcase
	end

endmodule

/* src/issue_pkg.sv */
package issue_pkg;

	localparam int word_width = 16;

	typedef logic [word_width-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	localparam lc3b_word word_zero = '0;

	// Only the opcodes this stage issues; anything else is unsupported
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_ldi = 4'b1010
	} lc3b_opcode;

	typedef enum logic [2:0]
	{
		class_alu,
		class_load,
		class_store,
		class_ldi,
		class_none
	} op_class_t;

	// One instruction word seen as ALU or memory format
	typedef union packed
	{
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_reg dest;
			lc3b_reg sr1;
			logic imm_flag;
			logic [4:0] field5;    // imm5, or sr2 in the low bits
		} alu;
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_reg data_reg;     // Dest for loads, source for stores
			lc3b_reg base_reg;
			logic [5:0] offset6;
		} mem;
	} instr_word_t;

endpackage
